//--- Makefile
VERILATOR ?= verilator
TOP       ?= fc_controller_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/fc_ctrl_pkg.sv
design/fc_layer_fsm.sv
design/mem_addr_ctrl.sv
design/pe_array_ctrl.sv
design/fc_controller_top.sv
verification/fc_controller_properties.sv
verification/fc_controller_tb.sv

//--- design/fc_controller_top.sv
`timescale 1ns/1ns
`default_nettype none

module fc_controller_top (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               en,
    input  fc_ctrl_pkg::fc_instr_t             inst,
    output fc_ctrl_pkg::inst_mem_ctrl_t        inst_mem,
    output fc_ctrl_pkg::act_mem_ctrl_t         act_mem,
    output fc_ctrl_pkg::param_mem_ctrl_t       param_mem,
    output fc_ctrl_pkg::pe_ctrl_t              pe,
    output logic                               done,
    output logic                               done_layer
);

    fc_ctrl_pkg::state_e                 state;
    logic [fc_ctrl_pkg::CNT_W-1:0]       phase_cnt;
    logic [fc_ctrl_pkg::TILE_W-1:0]      tile_cnt;
    fc_ctrl_pkg::fc_instr_t              instr;

    // Sequencing of layers and tiles
    fc_layer_fsm u_fsm (
        .clk        (clk),
        .resetn     (resetn),
        .en         (en),
        .inst       (inst),
        .state      (state),
        .phase_cnt  (phase_cnt),
        .tile_cnt   (tile_cnt),
        .instr      (instr),
        .done       (done),
        .done_layer (done_layer)
    );

    // Instruction, activation and parameter memory control
    mem_addr_ctrl u_mem_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .state     (state),
        .phase_cnt (phase_cnt),
        .tile_cnt  (tile_cnt),
        .instr     (instr),
        .inst_mem  (inst_mem),
        .act_mem   (act_mem),
        .param_mem (param_mem)
    );

    // PE array strobes
    pe_array_ctrl u_pe_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .state     (state),
        .phase_cnt (phase_cnt),
        .instr     (instr),
        .pe        (pe)
    );

endmodule

`default_nettype wire

//--- design/fc_ctrl_pkg.sv
`default_nettype none

package fc_ctrl_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int INST_W           = 80;
    localparam int INST_ADDR_W      = 6;
    localparam int ACT_ADDR_W       = 11;
    localparam int PARAM_ADDR_W     = 12;
    localparam int N_PES            = 16;
    localparam int TILE_W           = 8;
    localparam int PARAM_TILE_EXTRA = 3;    // bias, alpha, beta words per tile
    localparam int CNT_W            = 12;

    // PE write-enable masks for the two bias load cycles
    localparam logic [N_PES-1:0] WEA_LO_HALF = {{(N_PES/2){1'b0}}, {(N_PES/2){1'b1}}};
    localparam logic [N_PES-1:0] WEA_HI_HALF = {{(N_PES/2){1'b1}}, {(N_PES/2){1'b0}}};

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        OP_FC  = 3'd0,
        OP_END = 3'd7
    } opcode_e;

    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_FETCH  = 3'd1,
        S_DECODE = 3'd2,
        S_EXEC   = 3'd3,
        S_WB     = 3'd4,
        S_DONE   = 3'd5
    } state_e;

    ////////////////////////////////////////
    // Instruction word and control bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic [6:0]              rsvd_top;
        logic                    relu;       // bit 72
        logic                    ia_sign;    // bit 71
        logic [3:0]              rsvd_sign;
        logic [PARAM_ADDR_W-1:0] wgt_base;   // bits 66:55
        logic [4:0]              rsvd_wgt;
        logic [ACT_ADDR_W-1:0]   oa_base;    // bits 49:39
        logic [4:0]              rsvd_oa;
        logic [ACT_ADDR_W-1:0]   ia_base;    // bits 33:23
        logic [9:0]              n_minus1;
        logic [9:0]              m_minus1;
        opcode_e                 opcode;     // bits 2:0
    } fc_instr_t;

    typedef struct packed {
        logic                  rst_addr;
        logic                  en_addr;
        logic                  load_base;
        logic                  we;
        logic [ACT_ADDR_W-1:0] base_addr;
    } act_mem_ctrl_t;

    typedef struct packed {
        logic                    rst_addr;
        logic                    en_addr;
        logic                    load_base;
        logic [PARAM_ADDR_W-1:0] base_addr;
    } param_mem_ctrl_t;

    typedef struct packed {
        logic rst_addr;
        logic en_addr;
    } inst_mem_ctrl_t;

    typedef struct packed {
        logic             rst_pe;
        logic             shift;
        logic             load_bias;
        logic             act_sparsity_en;
        logic             ia_sign;
        logic             relu;
        logic [N_PES-1:0] wea;
    } pe_ctrl_t;

endpackage

`default_nettype wire

//--- design/fc_layer_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module fc_layer_fsm (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               en,
    input  fc_ctrl_pkg::fc_instr_t             inst,
    output fc_ctrl_pkg::state_e                state,
    output logic [fc_ctrl_pkg::CNT_W-1:0]      phase_cnt,
    output logic [fc_ctrl_pkg::TILE_W-1:0]     tile_cnt,
    output fc_ctrl_pkg::fc_instr_t             instr,
    output logic                               done,
    output logic                               done_layer
);

    fc_ctrl_pkg::state_e                 state_nxt;
    logic [fc_ctrl_pkg::CNT_W-1:0]       phase_nxt;
    logic [fc_ctrl_pkg::TILE_W-1:0]      tile_nxt;
    logic [fc_ctrl_pkg::CNT_W-1:0]       exec_last;
    logic [fc_ctrl_pkg::TILE_W-1:0]      tile_last;
    logic                                wb_last;
    logic                                layer_end;

    // EXEC runs phases 0..M+5, WB runs 0..N_PES+2
    assign exec_last = fc_ctrl_pkg::CNT_W'(instr.m_minus1) + fc_ctrl_pkg::CNT_W'(6);
    assign wb_last   = (phase_cnt == fc_ctrl_pkg::CNT_W'(fc_ctrl_pkg::N_PES + 2));

    // Last tile index T-1 as N is a multiple of N_PES
    assign tile_last = fc_ctrl_pkg::TILE_W'(instr.n_minus1 >> $clog2(fc_ctrl_pkg::N_PES));

    assign layer_end = (state == fc_ctrl_pkg::S_WB) && wb_last && !(tile_cnt < tile_last);

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb
    begin
        state_nxt = state;
        phase_nxt = phase_cnt;
        tile_nxt  = tile_cnt;
        case (state)
            fc_ctrl_pkg::S_IDLE:
            begin
                if (en)
                    state_nxt = fc_ctrl_pkg::S_FETCH;
            end
            fc_ctrl_pkg::S_FETCH:
                state_nxt = fc_ctrl_pkg::S_DECODE;
            fc_ctrl_pkg::S_DECODE:
            begin
                // Unknown opcodes park here
                case (instr.opcode)
                    fc_ctrl_pkg::OP_FC:  state_nxt = fc_ctrl_pkg::S_EXEC;
                    fc_ctrl_pkg::OP_END: state_nxt = fc_ctrl_pkg::S_DONE;
                    default:             state_nxt = fc_ctrl_pkg::S_DECODE;
                endcase
            end
            fc_ctrl_pkg::S_EXEC:
            begin
                if (phase_cnt == exec_last)
                begin
                    phase_nxt = '0;
                    state_nxt = fc_ctrl_pkg::S_WB;
                end
                else
                    phase_nxt = phase_cnt + 1'b1;
            end
            fc_ctrl_pkg::S_WB:
            begin
                if (wb_last)
                begin
                    phase_nxt = '0;
                    if (layer_end)
                    begin
                        tile_nxt  = '0;
                        state_nxt = fc_ctrl_pkg::S_FETCH;
                    end
                    else
                    begin
                        tile_nxt  = tile_cnt + 1'b1;
                        state_nxt = fc_ctrl_pkg::S_EXEC;
                    end
                end
                else
                    phase_nxt = phase_cnt + 1'b1;
            end
            fc_ctrl_pkg::S_DONE:
                state_nxt = fc_ctrl_pkg::S_DONE;
            default:
                state_nxt = fc_ctrl_pkg::S_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state      <= fc_ctrl_pkg::S_IDLE;
            phase_cnt  <= '0;
            tile_cnt   <= '0;
            instr      <= '0;
            done       <= 1'b0;
            done_layer <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            phase_cnt  <= phase_nxt;
            tile_cnt   <= tile_nxt;
            done       <= (state == fc_ctrl_pkg::S_DONE);
            done_layer <= layer_end;
            // Instruction word sampled at the end of FETCH
            if (state == fc_ctrl_pkg::S_FETCH)
                instr <= inst;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_addr_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_addr_ctrl (
    input  logic                               clk,
    input  logic                               resetn,
    input  fc_ctrl_pkg::state_e                state,
    input  logic [fc_ctrl_pkg::CNT_W-1:0]      phase_cnt,
    input  logic [fc_ctrl_pkg::TILE_W-1:0]     tile_cnt,
    input  fc_ctrl_pkg::fc_instr_t             instr,
    output fc_ctrl_pkg::inst_mem_ctrl_t        inst_mem,
    output fc_ctrl_pkg::act_mem_ctrl_t         act_mem,
    output fc_ctrl_pkg::param_mem_ctrl_t       param_mem
);

    fc_ctrl_pkg::inst_mem_ctrl_t             inst_nxt;
    fc_ctrl_pkg::act_mem_ctrl_t              act_nxt;
    fc_ctrl_pkg::param_mem_ctrl_t            param_nxt;
    logic [fc_ctrl_pkg::PARAM_ADDR_W-1:0]    wgt_off;
    logic [fc_ctrl_pkg::ACT_ADDR_W-1:0]      oa_off;
    logic [fc_ctrl_pkg::CNT_W-1:0]           m_len;
    logic                                    in_exec;
    logic                                    in_wb;
    logic                                    layer_end;

    assign m_len   = fc_ctrl_pkg::CNT_W'(instr.m_minus1) + fc_ctrl_pkg::CNT_W'(1);
    assign in_exec = (state == fc_ctrl_pkg::S_EXEC);
    assign in_wb   = (state == fc_ctrl_pkg::S_WB);

    // Last WB phase of the last tile
    assign layer_end = in_wb
        && (phase_cnt == fc_ctrl_pkg::CNT_W'(fc_ctrl_pkg::N_PES + 2))
        && !(tile_cnt < fc_ctrl_pkg::TILE_W'(instr.n_minus1 >> $clog2(fc_ctrl_pkg::N_PES)));

    ////////////////////////////////////////
    // Memory windows
    ////////////////////////////////////////
    always_comb
    begin
        inst_nxt.rst_addr = (state != fc_ctrl_pkg::S_IDLE);
        inst_nxt.en_addr  = (state == fc_ctrl_pkg::S_FETCH);
        act_nxt           = '0;
        act_nxt.rst_addr  = 1'b1;
        param_nxt          = '0;
        param_nxt.rst_addr = 1'b1;
        if (in_exec)
        begin
            // Tile start loads the weight and input bases
            if (phase_cnt == '0)
            begin
                param_nxt.load_base = 1'b1;
                param_nxt.base_addr = instr.wgt_base + wgt_off;
                act_nxt.load_base   = 1'b1;
                act_nxt.en_addr     = 1'b1;
                act_nxt.base_addr   = instr.ia_base;
            end
            if (phase_cnt >= fc_ctrl_pkg::CNT_W'(3) && phase_cnt <= m_len + 2'd2)
                act_nxt.en_addr = 1'b1;
            // Bias, alpha, beta and M weight words
            if (phase_cnt <= m_len + 2'd2)
                param_nxt.en_addr = 1'b1;
        end
        if (in_wb)
        begin
            if (phase_cnt == '0)
            begin
                act_nxt.load_base = 1'b1;
                act_nxt.base_addr = instr.oa_base + oa_off;
            end
            // One output word per PE
            if (phase_cnt >= fc_ctrl_pkg::CNT_W'(3)
                && phase_cnt <= fc_ctrl_pkg::CNT_W'(fc_ctrl_pkg::N_PES + 2))
            begin
                act_nxt.en_addr = 1'b1;
                act_nxt.we      = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Tile offsets and output registers
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wgt_off   <= '0;
            oa_off    <= '0;
            inst_mem  <= '{rst_addr: 1'b1, default: '0};
            act_mem   <= '{rst_addr: 1'b1, default: '0};
            param_mem <= '{rst_addr: 1'b1, default: '0};
        end
        else
        begin
            if (layer_end)
            begin
                wgt_off <= '0;
                oa_off  <= '0;
            end
            else if (in_exec && phase_cnt == '0)
                wgt_off <= wgt_off + fc_ctrl_pkg::PARAM_ADDR_W'(m_len)
                         + fc_ctrl_pkg::PARAM_ADDR_W'(fc_ctrl_pkg::PARAM_TILE_EXTRA);
            else if (in_wb && phase_cnt == '0)
                oa_off <= oa_off + fc_ctrl_pkg::ACT_ADDR_W'(fc_ctrl_pkg::N_PES);
            inst_mem  <= inst_nxt;
            act_mem   <= act_nxt;
            param_mem <= param_nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/pe_array_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module pe_array_ctrl (
    input  logic                               clk,
    input  logic                               resetn,
    input  fc_ctrl_pkg::state_e                state,
    input  logic [fc_ctrl_pkg::CNT_W-1:0]      phase_cnt,
    input  fc_ctrl_pkg::fc_instr_t             instr,
    output fc_ctrl_pkg::pe_ctrl_t              pe
);

    fc_ctrl_pkg::pe_ctrl_t            pe_nxt;
    logic [fc_ctrl_pkg::CNT_W-1:0]    m_len;

    assign m_len = fc_ctrl_pkg::CNT_W'(instr.m_minus1) + fc_ctrl_pkg::CNT_W'(1);

    always_comb
    begin
        pe_nxt         = '0;
        pe_nxt.rst_pe  = 1'b1;
        pe_nxt.ia_sign = instr.ia_sign;
        pe_nxt.relu    = instr.relu;
        if (state == fc_ctrl_pkg::S_EXEC)
        begin
            if (phase_cnt == '0)
                pe_nxt.rst_pe = 1'b0;
            // Bias enters the array in two halves
            if (phase_cnt == fc_ctrl_pkg::CNT_W'(2))
            begin
                pe_nxt.load_bias = 1'b1;
                pe_nxt.wea       = fc_ctrl_pkg::WEA_LO_HALF;
            end
            if (phase_cnt == fc_ctrl_pkg::CNT_W'(3))
            begin
                pe_nxt.load_bias = 1'b1;
                pe_nxt.wea       = fc_ctrl_pkg::WEA_HI_HALF;
            end
            if (phase_cnt >= fc_ctrl_pkg::CNT_W'(3) && phase_cnt <= m_len + 2'd2)
                pe_nxt.act_sparsity_en = 1'b1;
            // MAC accumulate runs two cycles behind the activation fetch
            if (phase_cnt >= fc_ctrl_pkg::CNT_W'(5) && phase_cnt <= m_len + 3'd4)
                pe_nxt.wea = '1;
        end
        // Shift partial sums out of the array
        if (state == fc_ctrl_pkg::S_WB && phase_cnt >= fc_ctrl_pkg::CNT_W'(1)
            && phase_cnt <= fc_ctrl_pkg::CNT_W'(fc_ctrl_pkg::N_PES))
        begin
            pe_nxt.shift = 1'b1;
            pe_nxt.wea   = '1;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            pe <= '{rst_pe: 1'b1, default: '0};
        else
            pe <= pe_nxt;
    end

endmodule

`default_nettype wire

//--- verification/fc_controller_properties.sv
`timescale 1ns/1ns
`default_nettype none

module fc_controller_properties (
    input logic                       clk,
    input logic                       resetn,
    input logic                       done,
    input logic                       done_layer,
    input fc_ctrl_pkg::act_mem_ctrl_t act_mem
);

    int assert_fail_cnt = 0;

    // DONE state is terminal
    done_sticky: assert property (@(posedge clk) disable iff (!resetn) done |=> done)
    else
    begin
        assert_fail_cnt++;
        $error("done fell after it was raised");
    end

    layer_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done_layer |=> !done_layer)
    else
    begin
        assert_fail_cnt++;
        $error("done_layer held longer than one cycle");
    end

    // Output writes only with the address running
    we_needs_en: assert property (@(posedge clk) disable iff (!resetn)
        act_mem.we |-> act_mem.en_addr)
    else
    begin
        assert_fail_cnt++;
        $error("act_mem.we without act_mem.en_addr");
    end

endmodule

bind fc_controller_top fc_controller_properties u_props (
    .clk        (clk),
    .resetn     (resetn),
    .done       (done),
    .done_layer (done_layer),
    .act_mem    (act_mem)
);

`default_nettype wire

//--- verification/fc_controller_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fc_controller_tb;

    localparam int RESET_CYCLES = 16;
    localparam int M_MAX        = 24;
    localparam int T_MAX        = 4;
    localparam int N_LAYERS     = 3;
    // Worst case of one layer is FETCH and DECODE plus EXEC and WB per tile
    localparam int LAYER_CYCLES = 2 + T_MAX * (M_MAX + 6 + fc_ctrl_pkg::N_PES + 3);
    localparam int WATCHDOG_NS  = 10 * (RESET_CYCLES + 4 + N_LAYERS * LAYER_CYCLES + 120);
    localparam logic [fc_ctrl_pkg::N_PES-1:0] LOWER_PES =
        {fc_ctrl_pkg::N_PES{1'b1}} >> (fc_ctrl_pkg::N_PES / 2);

    logic                          clk = 1'b0;
    logic                          resetn;
    logic                          en;
    fc_ctrl_pkg::fc_instr_t        inst;
    fc_ctrl_pkg::inst_mem_ctrl_t   inst_mem;
    fc_ctrl_pkg::act_mem_ctrl_t    act_mem;
    fc_ctrl_pkg::param_mem_ctrl_t  param_mem;
    fc_ctrl_pkg::pe_ctrl_t         pe;
    logic                          done;
    logic                          done_layer;
    int                            mismatch_cnt = 0;
    int                            other_cnt = 0;

    fc_controller_top DUT (
        .clk        (clk),
        .resetn     (resetn),
        .en         (en),
        .inst       (inst),
        .inst_mem   (inst_mem),
        .act_mem    (act_mem),
        .param_mem  (param_mem),
        .pe         (pe),
        .done       (done),
        .done_layer (done_layer)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_inst(input fc_ctrl_pkg::inst_mem_ctrl_t got,
                              input fc_ctrl_pkg::inst_mem_ctrl_t exp, input string what);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s, inst_mem %p expected %p", $time, what, got, exp);
        end
    endtask

    task automatic check_act(input fc_ctrl_pkg::act_mem_ctrl_t got,
                             input fc_ctrl_pkg::act_mem_ctrl_t exp, input string what);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s, act_mem %p expected %p", $time, what, got, exp);
        end
    endtask

    task automatic check_param(input fc_ctrl_pkg::param_mem_ctrl_t got,
                               input fc_ctrl_pkg::param_mem_ctrl_t exp, input string what);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s, param_mem %p expected %p", $time, what, got, exp);
        end
    endtask

    task automatic check_pe(input fc_ctrl_pkg::pe_ctrl_t got,
                            input fc_ctrl_pkg::pe_ctrl_t exp, input string what);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s, pe %p expected %p", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s, count %0d expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_reset();
        fc_ctrl_pkg::act_mem_ctrl_t   act_idle;
        fc_ctrl_pkg::param_mem_ctrl_t param_idle;
        fc_ctrl_pkg::pe_ctrl_t        pe_idle;
        act_idle   = '{rst_addr: 1'b1, default: '0};
        param_idle = '{rst_addr: 1'b1, default: '0};
        pe_idle    = '{rst_pe: 1'b1, default: '0};
        repeat (RESET_CYCLES) @(negedge clk);
        check_inst(inst_mem, '{rst_addr: 1'b1, en_addr: 1'b0}, "inst mem in reset");
        check_act(act_mem, act_idle, "act mem in reset");
        check_param(param_mem, param_idle, "param mem in reset");
        check_pe(pe, pe_idle, "pe in reset");
        check_count(int'(done) + int'(done_layer), 0, "done flags in reset");
        resetn = 1'b1;
        repeat (2) @(negedge clk);
        // Instruction address held in reset while idle
        check_inst(inst_mem, '{rst_addr: 1'b0, en_addr: 1'b0}, "inst mem in IDLE");
        check_act(act_mem, act_idle, "act mem in IDLE");
        check_param(param_mem, param_idle, "param mem in IDLE");
        check_pe(pe, pe_idle, "pe in IDLE");
    endtask

    // Runs one FC instruction up to done_layer and checks every tile
    task automatic run_fc_layer(input fc_ctrl_pkg::fc_instr_t ins);
        fc_ctrl_pkg::act_mem_ctrl_t   exp_act;
        fc_ctrl_pkg::param_mem_ctrl_t exp_param;
        fc_ctrl_pkg::pe_ctrl_t        exp_pe;
        int m;
        int t_cnt;
        int tile;
        int limit;
        int cycles;
        int fetches;
        int param_loads;
        int act_loads;
        int we_cnt[T_MAX];
        int act_rd_cnt[T_MAX];
        int param_en_cnt[T_MAX];
        int clear_cnt[T_MAX];
        int mac_cnt[T_MAX];
        int shift_cnt[T_MAX];
        int sparse_cnt[T_MAX];
        int bias_cnt[T_MAX];
        m            = int'(ins.m_minus1) + 1;
        t_cnt        = (int'(ins.n_minus1) + 1) / fc_ctrl_pkg::N_PES;
        limit        = 4 + t_cnt * (m + 6 + fc_ctrl_pkg::N_PES + 3);
        cycles       = 0;
        fetches      = 0;
        param_loads  = 0;
        act_loads    = 0;
        we_cnt       = '{default: 0};
        act_rd_cnt   = '{default: 0};
        param_en_cnt = '{default: 0};
        clear_cnt    = '{default: 0};
        mac_cnt      = '{default: 0};
        shift_cnt    = '{default: 0};
        sparse_cnt   = '{default: 0};
        bias_cnt     = '{default: 0};
        inst = ins;
        if (!en)
        begin
            @(negedge clk);
            en = 1'b1;
        end
        while (cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            if (inst_mem.en_addr)
            begin
                fetches++;
                check_inst(inst_mem, '{rst_addr: 1'b1, en_addr: 1'b1}, "instruction fetch");
            end
            if (param_mem.load_base)
            begin
                exp_param = '{rst_addr: 1'b1, en_addr: 1'b1, load_base: 1'b1,
                    base_addr: ins.wgt_base
                        + fc_ctrl_pkg::PARAM_ADDR_W'(param_loads * (m + 3))};
                check_param(param_mem, exp_param, $sformatf("weight base tile %0d", param_loads));
                param_loads++;
            end
            if (act_mem.load_base)
            begin
                // Even loads fetch inputs, odd loads place the outputs
                if (act_loads % 2 == 0)
                    exp_act = '{rst_addr: 1'b1, en_addr: 1'b1, load_base: 1'b1, we: 1'b0,
                        base_addr: ins.ia_base};
                else
                    exp_act = '{rst_addr: 1'b1, en_addr: 1'b0, load_base: 1'b1, we: 1'b0,
                        base_addr: ins.oa_base
                            + fc_ctrl_pkg::ACT_ADDR_W'((act_loads / 2) * fc_ctrl_pkg::N_PES)};
                check_act(act_mem, exp_act, $sformatf("act base load %0d", act_loads));
                act_loads++;
            end
            tile = param_loads - 1;
            if (tile >= 0 && tile < T_MAX)
            begin
                if (act_mem.we)
                    we_cnt[tile]++;
                else if (act_mem.en_addr)
                    act_rd_cnt[tile]++;
                if (param_mem.en_addr)
                    param_en_cnt[tile]++;
                if (pe.act_sparsity_en)
                    sparse_cnt[tile]++;
                // PE clear comes with the weight base load
                if (!pe.rst_pe)
                begin
                    exp_pe = '{rst_pe: 1'b0, shift: 1'b0, load_bias: 1'b0, act_sparsity_en: 1'b0,
                        ia_sign: ins.ia_sign, relu: ins.relu, wea: '0};
                    check_pe(pe, exp_pe, $sformatf("PE clear tile %0d", tile));
                    check_count(int'(param_mem.load_base), 1, "PE clear at tile start");
                    clear_cnt[tile]++;
                end
                if (pe.load_bias)
                begin
                    exp_pe = '{rst_pe: 1'b1, shift: 1'b0, load_bias: 1'b1,
                        act_sparsity_en: (bias_cnt[tile] == 1), ia_sign: ins.ia_sign,
                        relu: ins.relu, wea: (bias_cnt[tile] == 0) ? LOWER_PES : ~LOWER_PES};
                    check_pe(pe, exp_pe, $sformatf("bias load %0d tile %0d", bias_cnt[tile], tile));
                    bias_cnt[tile]++;
                end
                else if (pe.shift)
                begin
                    exp_pe = '{rst_pe: 1'b1, shift: 1'b1, load_bias: 1'b0, act_sparsity_en: 1'b0,
                        ia_sign: ins.ia_sign, relu: ins.relu, wea: '1};
                    check_pe(pe, exp_pe, $sformatf("output shift tile %0d", tile));
                    shift_cnt[tile]++;
                end
                else if (pe.wea == '1)
                begin
                    mac_cnt[tile]++;
                    check_count(bias_cnt[tile], 2, "bias halves before MAC");
                end
                else if (pe.wea != '0)
                begin
                    other_cnt++;
                    $display("ERROR at %0t: PE write enable outside any known pattern", $time);
                end
            end
            else if (act_mem.we || act_mem.en_addr || param_mem.en_addr || pe.shift
                || pe.load_bias || !pe.rst_pe || pe.wea != '0)
            begin
                other_cnt++;
                $display("ERROR at %0t: PE or memory activity outside a tile", $time);
            end
            if (done_layer)
                break;
        end
        if (!done_layer)
        begin
            other_cnt++;
            $display("ERROR: done_layer did not arrive within %0d cycles", limit);
        end
        check_count(fetches, 1, "instruction fetches");
        check_count(param_loads, t_cnt, "weight base loads");
        check_count(act_loads, 2 * t_cnt, "activation base loads");
        for (int i = 0; i < t_cnt && i < T_MAX; i++)
        begin
            check_count(we_cnt[i], fc_ctrl_pkg::N_PES, $sformatf("output writes tile %0d", i));
            check_count(act_rd_cnt[i], m + 1, $sformatf("input reads tile %0d", i));
            check_count(param_en_cnt[i], m + 3, $sformatf("parameter reads tile %0d", i));
            check_count(clear_cnt[i], 1, $sformatf("PE clears tile %0d", i));
            check_count(mac_cnt[i], m, $sformatf("MAC cycles tile %0d", i));
            check_count(shift_cnt[i], fc_ctrl_pkg::N_PES, $sformatf("shifts tile %0d", i));
            check_count(sparse_cnt[i], m, $sformatf("sparsity cycles tile %0d", i));
            check_count(bias_cnt[i], 2, $sformatf("bias loads tile %0d", i));
        end
    endtask

    task automatic test_fc_layer();
        fc_ctrl_pkg::fc_instr_t ins;
        int m;
        int t;
        m            = 1 + int'($urandom % M_MAX);
        t            = 1 + int'($urandom % T_MAX);
        ins          = '0;
        ins.opcode   = fc_ctrl_pkg::OP_FC;
        ins.m_minus1 = 10'(m - 1);
        ins.n_minus1 = 10'(t * fc_ctrl_pkg::N_PES - 1);
        ins.wgt_base = fc_ctrl_pkg::PARAM_ADDR_W'($urandom);
        ins.oa_base  = fc_ctrl_pkg::ACT_ADDR_W'($urandom);
        ins.ia_base  = fc_ctrl_pkg::ACT_ADDR_W'($urandom);
        ins.ia_sign  = 1'($urandom);
        ins.relu     = 1'($urandom);
        $display("FC layer with M=%0d T=%0d", m, t);
        run_fc_layer(ins);
    endtask

    task automatic test_end();
        fc_ctrl_pkg::fc_instr_t ins;
        int cycles;
        int layers;
        ins        = '0;
        ins.opcode = fc_ctrl_pkg::OP_END;
        inst       = ins;
        cycles     = 0;
        layers     = 0;
        while (!done && cycles < 8)
        begin
            @(negedge clk);
            cycles++;
            layers += int'(done_layer);
        end
        if (!done)
        begin
            other_cnt++;
            $display("ERROR: done did not rise after the END instruction");
        end
        // FETCH, DECODE, DONE, then the registered flag
        check_count(cycles, 3, "cycles from END fetch to done");
        repeat (8)
        begin
            @(negedge clk);
            check_count(int'(done), 1, "done held high");
            layers += int'(done_layer);
        end
        check_count(layers, 0, "done_layer pulses after END");
    endtask

    ////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////
    initial
    begin
        void'($urandom(32'h9bec_cbcc));
        resetn = 1'b0;
        en     = 1'b0;
        inst   = '0;
        test_reset();
        repeat (N_LAYERS) test_fc_layer();
        test_end();
        $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
            mismatch_cnt, other_cnt, DUT.u_props.assert_fail_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && DUT.u_props.assert_fail_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: timeout, tests still running after %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
